// File: common/rv_core_pkg.sv
package rv_core_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data and address width
  localparam int XLEN = 32;

  // Register index
  typedef logic [4:0] reg_addr_t;

  ////////////////////
  // Instruction set
  ////////////////////

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  ////////////////////
  // Control
  ////////////////////

  // Sequencer states
  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_SLEEP
  } ctrl_state_e;

  // Retired-instruction counter, low and high word
  localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
  localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

endpackage

// File: control/rv_ctrl_fsm.sv
`timescale 1ns/100ps

module rv_ctrl_fsm #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        fetch_enable_i,
  input  logic        bus_done_i,
  input  logic [31:0] bus_rdata_i,
  input  logic [31:0] next_pc_i,
  input  logic        is_mem_i,
  input  logic        is_store_i,
  input  logic        is_halt_i,
  input  logic [31:0] mem_addr_i,
  output logic        bus_req_o,
  output logic        bus_we_o,
  output logic [31:0] bus_adr_o,
  output logic [31:0] pc_o,
  output logic [31:0] instr_o,
  output logic        rf_we_o,
  output logic        retire_o,
  output logic        core_sleep_o
);

  rv_core_pkg::ctrl_state_e state_q, state_d;

  logic [31:0] pc_q;
  logic [31:0] instr_q;
  // Fetch owed after a data transfer, held back one cycle for the bus idle gap
  logic        fetch_req_q;

  ////////////////////
  // State register
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_core_pkg::S_IDLE:  if (fetch_enable_i) state_d = rv_core_pkg::S_FETCH;
      rv_core_pkg::S_FETCH: if (bus_done_i) state_d = rv_core_pkg::S_EXEC;
      rv_core_pkg::S_EXEC: begin
        if (is_halt_i) begin
          state_d = rv_core_pkg::S_SLEEP;
        end else if (is_mem_i) begin
          state_d = rv_core_pkg::S_MEM;
        end else begin
          state_d = rv_core_pkg::S_FETCH;
        end
      end
      rv_core_pkg::S_MEM:   if (bus_done_i) state_d = rv_core_pkg::S_FETCH;
      // Only reset wakes the core
      default:              state_d = rv_core_pkg::S_SLEEP;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= rv_core_pkg::S_IDLE;
      pc_q        <= BOOT_ADDR;
      fetch_req_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      fetch_req_q <= (state_q == rv_core_pkg::S_MEM) && bus_done_i;
      if (retire_o) begin
        pc_q <= next_pc_i;
      end
    end
  end

  // Instruction register, loaded in the fetch ack cycle
  always_ff @(posedge clk_i) begin
    if ((state_q == rv_core_pkg::S_FETCH) && bus_done_i) begin
      instr_q <= bus_rdata_i;
    end
  end

  ////////////////////
  // Bus requests
  ////////////////////

  // Start pulses: boot fetch, data or next fetch from execute, deferred fetch
  assign bus_req_o = ((state_q == rv_core_pkg::S_IDLE) && fetch_enable_i)
                   || ((state_q == rv_core_pkg::S_EXEC) && !is_halt_i)
                   || fetch_req_q;

  assign bus_we_o = (state_q == rv_core_pkg::S_EXEC) && is_mem_i && is_store_i;

  // PC is not yet updated in execute, so a direct fetch uses next_pc_i
  always_comb begin
    if (state_q == rv_core_pkg::S_EXEC) begin
      bus_adr_o = is_mem_i ? mem_addr_i : next_pc_i;
    end else begin
      bus_adr_o = pc_q;
    end
  end

  // Retire in the last cycle of each instruction
  assign retire_o = ((state_q == rv_core_pkg::S_EXEC) && !is_mem_i && !is_halt_i)
                  || ((state_q == rv_core_pkg::S_MEM) && bus_done_i);
  assign rf_we_o  = retire_o && !is_store_i;

  assign pc_o         = pc_q;
  assign instr_o      = instr_q;
  assign core_sleep_o = (state_q == rv_core_pkg::S_SLEEP);

  // One transfer in flight at a time
  a_one_transfer: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_req_o |=> (!bus_req_o throughout bus_done_i[->1]));

  // Branch and jump targets keep word alignment
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    pc_q[1:0] == 2'b00);

endmodule

// File: control/rv_instret_counter.sv
`timescale 1ns/100ps

module rv_instret_counter (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        retire_i,
  output logic [31:0] minstret_o
);

  logic [31:0] count_lo_q;
  logic [31:0] count_hi_q;
  logic [31:0] count_lo_inc;
  // Carry out of the low word
  logic        carry;

  assign {carry, count_lo_inc} = {1'b0, count_lo_q} + 33'd1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_lo_q <= '0;
      count_hi_q <= '0;
    end else if (retire_i) begin
      count_lo_q <= count_lo_inc;
      count_hi_q <= count_hi_q + {31'd0, carry};
    end
  end

  // Only the low word is visible as a CSR
  assign minstret_o = count_lo_q;

  // Full 64-bit count is monotonic
  a_monotonic: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> {count_hi_q, count_lo_q} >= $past({count_hi_q, count_lo_q}));

endmodule

// File: execute/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
  input  logic [31:0]            instr_i,
  input  logic [31:0]            pc_i,
  input  logic [31:0]            rs1_data_i,
  input  logic [31:0]            rs2_data_i,
  input  logic [31:0]            load_data_i,
  input  logic [31:0]            minstret_i,
  output rv_core_pkg::reg_addr_t rs1_addr_o,
  output rv_core_pkg::reg_addr_t rs2_addr_o,
  output rv_core_pkg::reg_addr_t rd_addr_o,
  output logic [31:0]            rd_data_o,
  output logic [31:0]            store_data_o,
  output logic [31:0]            mem_addr_o,
  output logic [31:0]            next_pc_o,
  output logic                   is_mem_o,
  output logic                   is_store_o,
  output logic                   is_halt_o
);

  localparam int W = rv_core_pkg::XLEN;

  ////////////////////
  // Field decode
  ////////////////////

  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [11:0]  csr_num;
  logic [W-1:0] imm_i;
  logic [W-1:0] imm_s;
  logic [W-1:0] imm_b;
  logic [W-1:0] imm_u;
  logic [W-1:0] imm_j;

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign csr_num = instr_i[31:20];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'd0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  ////////////////////
  // Operand and op select
  ////////////////////

  rv_core_pkg::alu_op_e alu_op;
  logic [W-1:0] op_b;
  logic [W-1:0] alu_res;
  logic         has_rd;
  logic         csr_ok;

  // CSRRS on minstret is the only system op besides EBREAK
  assign csr_ok = (funct3 == 3'b010) && (csr_num == rv_core_pkg::CSR_MINSTRET);

  always_comb begin
    alu_op    = rv_core_pkg::ALU_ADD;
    op_b      = imm_i;
    has_rd    = 1'b0;
    is_halt_o = 1'b0;
    case (opcode)
      rv_core_pkg::OP: begin
        op_b   = rs2_data_i;
        has_rd = 1'b1;
        case (funct3)
          3'b100:  alu_op = rv_core_pkg::ALU_XOR;
          3'b110:  alu_op = rv_core_pkg::ALU_OR;
          3'b111:  alu_op = rv_core_pkg::ALU_AND;
          default: alu_op = instr_i[30] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
        endcase
      end
      rv_core_pkg::OP_IMM, rv_core_pkg::LOAD, rv_core_pkg::JAL: has_rd = 1'b1;
      rv_core_pkg::LUI: begin
        alu_op = rv_core_pkg::ALU_PASS_B;
        op_b   = imm_u;
        has_rd = 1'b1;
      end
      rv_core_pkg::STORE:  op_b = imm_s;
      rv_core_pkg::BRANCH: op_b = rs2_data_i;
      rv_core_pkg::SYSTEM: begin
        has_rd    = csr_ok;
        is_halt_o = !csr_ok;
      end
      // Anything outside the subset behaves like EBREAK
      default: is_halt_o = 1'b1;
    endcase
  end

  ////////////////////
  // ALU and branch
  ////////////////////

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_SUB:    alu_res = rs1_data_i - op_b;
      rv_core_pkg::ALU_AND:    alu_res = rs1_data_i & op_b;
      rv_core_pkg::ALU_OR:     alu_res = rs1_data_i | op_b;
      rv_core_pkg::ALU_XOR:    alu_res = rs1_data_i ^ op_b;
      rv_core_pkg::ALU_PASS_B: alu_res = op_b;
      default:                 alu_res = rs1_data_i + op_b;
    endcase
  end

  logic         take_branch;
  logic [W-1:0] pc_plus4;

  // funct3[0] selects BNE over BEQ
  assign take_branch = (opcode == rv_core_pkg::BRANCH)
                     && ((rs1_data_i == rs2_data_i) ^ funct3[0]);
  assign pc_plus4    = pc_i + 32'd4;

  always_comb begin
    if (opcode == rv_core_pkg::JAL) begin
      next_pc_o = pc_i + imm_j;
    end else if (take_branch) begin
      next_pc_o = pc_i + imm_b;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

  ////////////////////
  // Results
  ////////////////////

  always_comb begin
    case (opcode)
      rv_core_pkg::JAL:    rd_data_o = pc_plus4;
      rv_core_pkg::SYSTEM: rd_data_o = minstret_i;
      rv_core_pkg::LOAD:   rd_data_o = load_data_i;
      default:             rd_data_o = alu_res;
    endcase
  end

  // No destination means x0, so the write is dropped
  assign rd_addr_o    = has_rd ? instr_i[11:7] : '0;
  assign mem_addr_o   = alu_res;
  assign store_data_o = rs2_data_i;
  assign is_store_o   = (opcode == rv_core_pkg::STORE);
  assign is_mem_o     = is_store_o || (opcode == rv_core_pkg::LOAD);

endmodule

// File: execute/rv_wb_master.sv
`timescale 1ns/100ps

module rv_wb_master (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] wdata_i,
  output logic        done_o,
  output logic [31:0] rdata_o,
  // Wishbone classic
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack_i,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output logic [31:0] wb_adr_o,
  output logic [31:0] wb_dat_o,
  output logic [3:0]  wb_sel_o
);

  logic        cyc_q;
  logic        we_q;
  logic [31:0] adr_q;
  logic [31:0] dat_q;
  logic [31:0] rdata_q;

  // Request fields latched on the start pulse, held until ack
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cyc_q <= 1'b0;
      we_q  <= 1'b0;
      adr_q <= '0;
      dat_q <= '0;
    end else if (req_i) begin
      cyc_q <= 1'b1;
      we_q  <= we_i;
      adr_q <= adr_i;
      dat_q <= wdata_i;
    end else if (done_o) begin
      cyc_q <= 1'b0;
      we_q  <= 1'b0;
    end
  end

  // Read data kept until the next transfer
  always_ff @(posedge clk_i) begin
    if (done_o) begin
      rdata_q <= wb_dat_i;
    end
  end

  assign done_o = cyc_q && wb_ack_i;
  // Ack cycle passes bus data straight through for same-cycle use
  assign rdata_o = done_o ? wb_dat_i : rdata_q;

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  // Whole words only
  assign wb_sel_o = {4{cyc_q}};

  // Slave stall keeps the request steady
  a_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f src.f -o tb_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log

grep -qx "Regression passed" sim.log && echo "Simulation OK" \
  || { echo "Simulation reported failure"; exit 1; }

// File: src.f
common/rv_core_pkg.sv
verilog/rv_regfile.sv
control/rv_ctrl_fsm.sv
control/rv_instret_counter.sv
execute/rv_execute.sv
execute/rv_wb_master.sv
verilog/rv_core_top.sv
verification/tb_clock_gen.sv
verification/tb_top.sv

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for the first 4 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (4) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/100ps

module tb_top;

  localparam logic [31:0] BOOT_ADDR   = 32'h0000_0000;
  localparam int          N_INSTR     = 200;
  localparam int          MEM_WORDS   = 1024;
  localparam logic [31:0] DATA_BASE   = 32'h0000_0600;
  localparam int          DATA_WORDS  = 64;
  // Two transfers per instruction, worst stall plus handshake, plus margin
  localparam int          WATCHDOG_NS = N_INSTR * 2 * (3 + 2) * 4 + 8000;

  logic        clk;
  logic        reset;
  logic        fetch_enable = 1'b0;
  logic [31:0] wb_dat_i = 32'd0;
  logic        wb_ack_i = 1'b0;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [31:0] wb_adr_o;
  logic [31:0] wb_dat_o;
  logic [3:0]  wb_sel_o;
  logic        core_sleep_o;

  integer seed = 30;

  // Bus-side memory and the model's own copy
  logic [31:0] bus_mem   [MEM_WORDS];
  logic [31:0] model_mem [MEM_WORDS];

  // Instruction-set model state
  logic [31:0] model_pc;
  logic [31:0] model_regs [32];
  // Origin of a register value: 0 ALU, 1 load, 2 minstret
  int          model_src [32];
  int          model_retired;
  int          model_stores;
  logic        model_halted;

  // Pending data transfer predicted by the model
  logic        exp_data_pending;
  logic        exp_we;
  logic [31:0] exp_adr;
  logic [31:0] exp_wdata;
  int          exp_src;

  int          dut_stores;
  logic        first_transfer;
  logic        slave_active;
  int          stall;

  // Error counts per test
  int          errs [6];
  string       test_names [6] = '{"reset_start", "fetch_order", "store_contents",
                                  "loads", "retire_count", "sleep"};

  tb_clock_gen clock_gen_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  rv_core_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) i_rv_core_top (
    .clk_i          (clk),
    .reset_i        (reset),
    .fetch_enable_i (fetch_enable),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_we_o        (wb_we_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_o       (wb_dat_o),
    .wb_sel_o       (wb_sel_o),
    .core_sleep_o   (core_sleep_o)
  );

  ////////////////////
  // Encoders
  ////////////////////

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // x1..x15 so values get reused often
  function automatic logic [4:0] rand_reg();
    return 5'(1 + {$random(seed)} % 15);
  endfunction

  ////////////////////
  // Program generator
  ////////////////////

  task automatic gen_program();
    int          i;
    int          kind;
    int          n;
    logic [4:0]  rd;
    logic [31:0] w;
    logic [11:0] off;
    // Background fill from the full byte address
    for (int a = 0; a < MEM_WORDS; a++) begin
      bus_mem[a] = {a[29:0], 2'b00} ^ 32'h5A5A_C3C3;
    end
    for (int k = 0; k < DATA_WORDS; k++) begin
      bus_mem[DATA_BASE[11:2] + k] = $random(seed);
    end
    i = 0;
    while (i < N_INSTR) begin
      kind = {$random(seed)} % 10;
      rd   = rand_reg();
      off  = 12'(DATA_BASE + 4 * ({$random(seed)} % DATA_WORDS));
      case (kind)
        0, 1: begin
          case ({$random(seed)} % 5)
            0:       w = enc_r(7'h00, rand_reg(), rand_reg(), 3'b000, rd);
            1:       w = enc_r(7'h20, rand_reg(), rand_reg(), 3'b000, rd);
            2:       w = enc_r(7'h00, rand_reg(), rand_reg(), 3'b100, rd);
            3:       w = enc_r(7'h00, rand_reg(), rand_reg(), 3'b110, rd);
            default: w = enc_r(7'h00, rand_reg(), rand_reg(), 3'b111, rd);
          endcase
        end
        2: w = enc_i(12'($random(seed)), rand_reg(), 3'b000, rd, 7'b0010011);
        3: w = {20'($random(seed)), rd, 7'b0110111};
        4: w = enc_i(off, 5'd0, 3'b010, rd, 7'b0000011);
        5, 6: w = enc_s(off, rand_reg());
        7, 8: begin
          // Forward only, landing at most on the closing EBREAK
          n = 2 + {$random(seed)} % 6;
          if (i + n > N_INSTR) n = N_INSTR - i;
          if (kind == 7) begin
            w = enc_b(13'(4 * n), rand_reg(), rand_reg(),
                      ({$random(seed)} % 2 == 0) ? 3'b000 : 3'b001);
          end else begin
            w = enc_j(21'(4 * n), rd);
          end
        end
        default: begin
          // CSRRS rd, minstret, x0 and a store of rd right after
          w = enc_i(rv_core_pkg::CSR_MINSTRET, 5'd0, 3'b010, rd, 7'b1110011);
          if (i + 1 < N_INSTR) begin
            bus_mem[BOOT_ADDR[11:2] + i] = w;
            i++;
            w = enc_s(off, rd);
          end
        end
      endcase
      bus_mem[BOOT_ADDR[11:2] + i] = w;
      i++;
    end
    bus_mem[BOOT_ADDR[11:2] + N_INSTR] = 32'h0010_0073;
    for (int a = 0; a < MEM_WORDS; a++) begin
      model_mem[a] = bus_mem[a];
    end
  endtask

  ////////////////////
  // Instruction-set model
  ////////////////////

  task automatic model_step();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [31:0] addr;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        wr;
    int          src;
    ins = model_mem[model_pc[11:2]];
    rd  = ins[11:7];
    f3  = ins[14:12];
    a   = model_regs[ins[19:15]];
    b   = model_regs[ins[24:20]];
    nxt = model_pc + 32'd4;
    res = 32'd0;
    wr  = 1'b0;
    src = 0;
    case (ins[6:0])
      7'b0110011: begin
        wr = 1'b1;
        case (f3)
          3'b100:  res = a ^ b;
          3'b110:  res = a | b;
          3'b111:  res = a & b;
          default: res = ins[30] ? a - b : a + b;
        endcase
      end
      7'b0010011: begin
        wr  = 1'b1;
        res = a + {{20{ins[31]}}, ins[31:20]};
      end
      7'b0110111: begin
        wr  = 1'b1;
        res = {ins[31:12], 12'd0};
      end
      7'b0000011: begin
        addr             = a + {{20{ins[31]}}, ins[31:20]};
        exp_data_pending = 1'b1;
        exp_we           = 1'b0;
        exp_adr          = addr;
        res              = model_mem[addr[11:2]];
        wr               = 1'b1;
        src              = 1;
      end
      7'b0100011: begin
        addr             = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_data_pending = 1'b1;
        exp_we           = 1'b1;
        exp_adr          = addr;
        exp_wdata        = b;
        exp_src          = model_src[ins[24:20]];
        model_mem[addr[11:2]] = b;
        model_stores++;
      end
      7'b1100011: begin
        if ((a == b) ^ f3[0]) begin
          nxt = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        wr  = 1'b1;
        res = model_pc + 32'd4;
        nxt = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b1110011: begin
        if (f3 == 3'b010 && ins[31:20] == rv_core_pkg::CSR_MINSTRET) begin
          wr  = 1'b1;
          res = 32'(model_retired);
          src = 2;
        end else begin
          model_halted = 1'b1;
        end
      end
      // Unknown opcodes halt like EBREAK
      default: model_halted = 1'b1;
    endcase
    if (!model_halted) begin
      if (wr && rd != 5'd0) begin
        model_regs[rd] = res;
        model_src[rd]  = src;
      end
      model_retired++;
      model_pc = nxt;
    end
  endtask

  ////////////////////
  // Transfer checks
  ////////////////////

  task automatic check_transfer();
    int t;
    assert (!model_halted) else begin
      $display("Bus transfer to %h started after EBREAK", wb_adr_o);
      errs[5]++;
    end
    // Every write the core issues counts, expected or not
    if (wb_we_o) begin
      dut_stores++;
    end
    if (first_transfer) begin
      first_transfer = 1'b0;
      assert (wb_adr_o == BOOT_ADDR && !wb_we_o) else begin
        $display("MISMATCH wb_adr_o: got %h expected %h", wb_adr_o, BOOT_ADDR);
        errs[0]++;
      end
    end
    if (exp_data_pending) begin
      exp_data_pending = 1'b0;
      // Stored values are graded by where the register value came from
      t = exp_we ? 2 + exp_src : 3;
      assert (wb_we_o == exp_we) else begin
        $display("MISMATCH wb_we_o: got %h expected %h", wb_we_o, exp_we);
        errs[t]++;
      end
      assert (wb_adr_o == exp_adr) else begin
        $display("MISMATCH wb_adr_o: got %h expected %h", wb_adr_o, exp_adr);
        errs[t]++;
      end
      if (exp_we) begin
        assert (wb_dat_o == exp_wdata) else begin
          $display("MISMATCH wb_dat_o: got %h expected %h", wb_dat_o, exp_wdata);
          errs[t]++;
        end
        assert (wb_sel_o == 4'hF) else begin
          $display("MISMATCH wb_sel_o: got %h expected %h", wb_sel_o, 4'hF);
          errs[t]++;
        end
      end
    end else if (!model_halted) begin
      assert (!wb_we_o && wb_adr_o == model_pc) else begin
        $display("MISMATCH wb_adr_o: got %h expected %h (fetch, we %h)",
                 wb_adr_o, model_pc, wb_we_o);
        errs[1]++;
      end
      model_step();
    end
  endtask

  ////////////////////
  // Memory slave
  ////////////////////

  // Random stall of 0 to 3 cycles, ack held for one cycle
  always @(posedge clk) begin
    if (reset) begin
      wb_ack_i     <= 1'b0;
      slave_active  = 1'b0;
    end else if (wb_ack_i) begin
      wb_ack_i <= 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!slave_active) begin
        slave_active = 1'b1;
        stall        = {$random(seed)} % 4;
        check_transfer();
      end
      if (stall == 0) begin
        slave_active = 1'b0;
        wb_ack_i    <= 1'b1;
        if (wb_we_o) begin
          bus_mem[wb_adr_o[11:2]] = wb_dat_o;
        end else begin
          wb_dat_i <= bus_mem[wb_adr_o[11:2]];
        end
      end else begin
        stall--;
      end
    end
  end

  // Quiet bus before start, no sleep before EBREAK
  always @(posedge clk) begin
    if (reset || !fetch_enable) begin
      assert (!wb_cyc_o && !wb_stb_o && !core_sleep_o) else begin
        $display("Core active during reset or before fetch enable");
        errs[0]++;
      end
    end
    if (core_sleep_o) begin
      assert (model_halted) else begin
        $display("core_sleep_o high before the model reached EBREAK");
        errs[5]++;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int fails;
    model_pc         = BOOT_ADDR;
    model_retired    = 0;
    model_stores     = 0;
    model_halted     = 1'b0;
    exp_data_pending = 1'b0;
    exp_we           = 1'b0;
    exp_adr          = 32'd0;
    exp_wdata        = 32'd0;
    exp_src          = 0;
    dut_stores       = 0;
    first_transfer   = 1'b1;
    slave_active     = 1'b0;
    stall            = 0;
    fails            = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'd0;
      model_src[r]  = 0;
    end
    for (int t = 0; t < 6; t++) begin
      errs[t] = 0;
    end
    gen_program();
    while (reset) @(posedge clk);
    repeat (8) @(posedge clk);
    fetch_enable <= 1'b1;
    // Watchdog bounds this wait
    while (!core_sleep_o) @(posedge clk);
    // Idle window where any new transfer would be flagged
    repeat (20) @(posedge clk);
    assert (model_halted && !wb_cyc_o) else begin
      $display("Core asleep but model not halted or bus still active");
      errs[5]++;
    end
    assert (dut_stores == model_stores) else begin
      $display("MISMATCH store_count: got %h expected %h", dut_stores, model_stores);
      errs[5]++;
    end
    for (int t = 0; t < 6; t++) begin
      $display("Test %-14s %s (%0d errors)", test_names[t],
               (errs[t] == 0) ? "PASS" : "FAIL", errs[t]);
      if (errs[t] != 0) fails++;
    end
    $display("Tests: %0d passed, %0d failed", 6 - fails, fails);
    if (fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: core did not reach sleep within %0d ns", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        fetch_enable_i,
  // Wishbone classic master
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack_i,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output logic [31:0] wb_adr_o,
  output logic [31:0] wb_dat_o,
  output logic [3:0]  wb_sel_o,
  output logic        core_sleep_o
);

  // Sequencer to bus master
  logic        bus_req;
  logic        bus_we;
  logic [31:0] bus_adr;
  logic        bus_done;
  logic [31:0] bus_rdata;

  // Sequencer to execute
  logic [31:0] pc;
  logic [31:0] instr;
  logic [31:0] next_pc;
  logic [31:0] mem_addr;
  logic [31:0] store_data;
  logic        is_mem;
  logic        is_store;
  logic        is_halt;

  // Register file ports
  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::reg_addr_t rd_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] rd_data;
  logic        rf_we;

  // Retire count
  logic        retire;
  logic [31:0] minstret;

  ////////////////////
  // Sequencer
  ////////////////////

  rv_ctrl_fsm #(
    .BOOT_ADDR (BOOT_ADDR)
  ) ctrl_fsm_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .bus_done_i     (bus_done),
    .bus_rdata_i    (bus_rdata),
    .next_pc_i      (next_pc),
    .is_mem_i       (is_mem),
    .is_store_i     (is_store),
    .is_halt_i      (is_halt),
    .mem_addr_i     (mem_addr),
    .bus_req_o      (bus_req),
    .bus_we_o       (bus_we),
    .bus_adr_o      (bus_adr),
    .pc_o           (pc),
    .instr_o        (instr),
    .rf_we_o        (rf_we),
    .retire_o       (retire),
    .core_sleep_o   (core_sleep_o)
  );

  ////////////////////
  // Datapath
  ////////////////////

  rv_execute execute_i (
    .instr_i      (instr),
    .pc_i         (pc),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .load_data_i  (bus_rdata),
    .minstret_i   (minstret),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rd_addr_o    (rd_addr),
    .rd_data_o    (rd_data),
    .store_data_o (store_data),
    .mem_addr_o   (mem_addr),
    .next_pc_o    (next_pc),
    .is_mem_o     (is_mem),
    .is_store_o   (is_store),
    .is_halt_o    (is_halt)
  );

  rv_regfile regfile_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .we_i      (rf_we),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .waddr_i   (rd_addr),
    .wdata_i   (rd_data),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  rv_instret_counter instret_counter_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .retire_i   (retire),
    .minstret_o (minstret)
  );

  ////////////////////
  // Bus
  ////////////////////

  rv_wb_master wb_master_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (bus_req),
    .we_i     (bus_we),
    .adr_i    (bus_adr),
    .wdata_i  (store_data),
    .done_o   (bus_done),
    .rdata_o  (bus_rdata),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_sel_o (wb_sel_o)
  );

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   we_i,
  input  rv_core_pkg::reg_addr_t raddr_a_i,
  input  rv_core_pkg::reg_addr_t raddr_b_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  input  logic [31:0]            wdata_i,
  output logic [31:0]            rdata_a_o,
  output logic [31:0]            rdata_b_o
);

  // x1..x31, x0 has no storage
  logic [31:0] regs_q [1:31];

  // Write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read, x0 reads zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule
